/* include/fpmul_config.svh */
/*
 * Configuration macros for the fp16 multiply unit.
 * Holds the field widths, the exponent bias, the AXI4-Lite address width
 * and the byte offsets of the host-visible registers.
 */
`ifndef FPMUL_CONFIG_SVH
`define FPMUL_CONFIG_SVH

// Significand width with the hidden bit included.
`define FPMUL_MANT_BITS 11
`define FPMUL_EXP_BITS 5
`define FPMUL_EXP_BIAS 15

`define FPMUL_AXI_ADDR_BITS 5

// Register map, byte addresses on the AXI4-Lite bus.
`define FPMUL_REG_OPA 5'h00
`define FPMUL_REG_OPB 5'h04
`define FPMUL_REG_CTRL 5'h08
`define FPMUL_REG_STATUS 5'h0C
`define FPMUL_REG_RESULT 5'h10

`endif

/* hdl/fpmul_pkg.sv */
/*
 * Shared types of the fp16 multiply unit.
 * Contains the binary16 field struct, the operand word union
 * and the state encoding of the multiply sequencer.
 */
`include "fpmul_config.svh"

package fpmul_pkg;

    // One binary16 value split into its three fields, sign in the top bit.
    typedef struct packed {
        logic                         sign;
        logic [`FPMUL_EXP_BITS-1:0]   exponent;
        logic [`FPMUL_MANT_BITS-2:0]  fraction;
    } fp16_fields_t;

    // An operand register is written by the host as a raw code.
    // The datapath reads the same bits as separate fields.
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t fields;
    } fp16_word_t;

    // Sequencer states.
    // CAPTURE doubles as the done state and holds until the next start.
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        MULTIPLY = 2'd1,
        CAPTURE  = 2'd2
    } mul_state_t;

endpackage

/* hdl/mul_multicycle.sv */
/*
 * Iterative unsigned shift-add multiplier, one multiplier bit per clock.
 * Returns the upper product bits plus the R and S bits, the top product bit
 * and a sticky flag for the truncated low bits.
 */
`timescale 1ns/1ps

module mul_multicycle #(
    parameter int num_bits = 11
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,
    input  logic                  stop,
    input  logic [num_bits-1:0]   op1,
    input  logic [num_bits-1:0]   op2,
    output logic [num_bits+1:0]   result,
    output logic                  overflow,
    output logic                  round_loss
);

    logic [num_bits-1:0]    multiplicand;
    logic [2*num_bits-1:0]  product;
    logic [2*num_bits-1:0]  next_product;
    logic [num_bits:0]      partial;

    // Upper half plus multiplicand, one bit wider to keep the carry.
    assign partial = {1'b0, product[2*num_bits-1:num_bits]} + {1'b0, multiplicand};

    // The top bit tells the rounding logic that the significand product reached 2.0.
    assign overflow = product[2*num_bits-1];
    // The window starts below the top bit and ends with the two extra rounding bits.
    assign result = product[2*num_bits-2 -: num_bits+2];
    // Bits below the returned window only matter as a sticky OR.
    assign round_loss = |product[num_bits-4:0];

    always_comb begin
        next_product = product;
        if (start) begin
            // The multiplier operand sits in the low half and is consumed from bit 0.
            next_product = {{num_bits{1'b0}}, op2};
        end else if (!stop) begin
            if (product[0]) begin
                next_product = {partial, product[num_bits-1:1]};
            end else begin
                next_product = product >> 1;
            end
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            product <= '0;
        end else begin
            product <= next_product;
        end
    end

    // The multiplicand only changes on start.
    always_ff @(posedge clk) begin
        if (start) begin
            multiplicand <= op1;
        end
    end

endmodule

/* hdl/mul_cycle_timer.sv */
/*
 * Iteration timer for the multi-cycle multiplier.
 * Loads the iteration count on start and holds stop once it reaches zero.
 */
`timescale 1ns/1ps

module mul_cycle_timer #(
    parameter int count_bits = 11
) (
    input  logic clk,
    input  logic nRST,
    input  logic start,
    output logic stop
);

    localparam int CNT_W = $clog2(count_bits + 1);

    logic [CNT_W-1:0] count;
    logic             armed;

    // Out of reset no multiply has run, so stop stays low until the first start.
    assign stop = armed && (count == '0);

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            count <= '0;
            armed <= 1'b0;
        end else if (start) begin
            count <= CNT_W'(count_bits);
            armed <= 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* hdl/mul_fsm.sv */
/*
 * Multiply sequencer.
 * Turns a start request into the multiplier start pulse, waits for the
 * timer, pulses result capture and reports busy and done.
 */
`timescale 1ns/1ps

module mul_fsm
    import fpmul_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    input  logic start_req,
    input  logic stop,
    output logic mul_start,
    output logic capture,
    output logic busy,
    output logic done
);

    mul_state_t state;
    mul_state_t next_state;
    logic       start_pulse;

    assign busy = (state == MULTIPLY);
    assign done = (state == CAPTURE);

    always_comb begin
        next_state  = state;
        start_pulse = 1'b0;
        capture     = 1'b0;
        case (state)
            IDLE, CAPTURE: begin
                // A new request also clears done by leaving CAPTURE.
                if (start_req) begin
                    next_state  = MULTIPLY;
                    start_pulse = 1'b1;
                end
            end
            MULTIPLY: begin
                // While mul_start is still high the timer has not reloaded.
                // Its stop output is left over from the previous run then.
                if (stop && !mul_start) begin
                    capture    = 1'b1;
                    next_state = CAPTURE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            state     <= IDLE;
            mul_start <= 1'b0;
        end else begin
            state     <= next_state;
            mul_start <= start_pulse;
        end
    end

endmodule

/* hdl/fp16_sign_exp_round.sv */
/*
 * Sign, exponent and rounding stage of the fp16 multiply.
 * Builds the hidden-bit significands, normalizes the product, rounds to
 * nearest even and registers the packed result with its inexact flag.
 */
`timescale 1ns/1ps
`include "fpmul_config.svh"

module fp16_sign_exp_round
    import fpmul_pkg::*;
(
    input  logic                         clk,
    input  logic                         nRST,
    input  logic                         capture,
    input  fp16_word_t                   op_a,
    input  fp16_word_t                   op_b,
    input  logic [`FPMUL_MANT_BITS+1:0]  product,
    input  logic                         overflow,
    input  logic                         round_loss,
    output logic [`FPMUL_MANT_BITS-1:0]  mant_a,
    output logic [`FPMUL_MANT_BITS-1:0]  mant_b,
    output logic [15:0]                  result_word,
    output logic                         inexact
);

    localparam int FRAC_BITS = `FPMUL_MANT_BITS - 1;
    localparam int EXP_W = `FPMUL_EXP_BITS + 2;
    localparam int EXP_MAX = (1 << `FPMUL_EXP_BITS) - 1;

    logic                    zero_a;
    logic                    zero_b;
    logic                    sign;
    logic [FRAC_BITS-1:0]    frac;
    logic                    guard;
    logic                    sticky;
    logic                    round_up;
    logic [FRAC_BITS:0]      frac_rnd;
    logic signed [EXP_W-1:0] exp_sum;
    logic signed [EXP_W-1:0] exp_fin;
    logic [15:0]             word_next;
    logic                    inexact_next;

    // Subnormals are flushed, so a zero exponent field means a zero significand.
    assign zero_a = (op_a.fields.exponent == '0);
    assign zero_b = (op_b.fields.exponent == '0);
    assign mant_a = zero_a ? '0 : {1'b1, op_a.fields.fraction};
    assign mant_b = zero_b ? '0 : {1'b1, op_b.fields.fraction};

    assign sign = op_a.fields.sign ^ op_b.fields.sign;

    always_comb begin
        // Two extra exponent bits hold the sign and the headroom past the max code.
        exp_sum = EXP_W'(op_a.fields.exponent) + EXP_W'(op_b.fields.exponent)
                  - EXP_W'(`FPMUL_EXP_BIAS) + EXP_W'(overflow);

        // A product of 2.0 or more shifts the window up by one bit.
        if (overflow) begin
            frac   = product[FRAC_BITS+2:3];
            guard  = product[2];
            sticky = (|product[1:0]) | round_loss;
        end else begin
            frac   = product[FRAC_BITS+1:2];
            guard  = product[1];
            sticky = product[0] | round_loss;
        end

        // Ties go to the even fraction.
        round_up = guard & (sticky | frac[0]);
        frac_rnd = {1'b0, frac} + (FRAC_BITS + 1)'(round_up);
        // A carry out of the fraction means 1.11..1 rounded to 10.00..0.
        exp_fin = exp_sum + EXP_W'(frac_rnd[FRAC_BITS]);

        if (zero_a || zero_b) begin
            word_next    = {sign, 15'b0};
            inexact_next = 1'b0;
        end else if (exp_fin >= EXP_MAX) begin
            word_next    = {sign, {`FPMUL_EXP_BITS{1'b1}}, {FRAC_BITS{1'b0}}};
            inexact_next = 1'b1;
        end else if (exp_fin <= 0) begin
            // Without gradual underflow the whole value is lost.
            word_next    = {sign, 15'b0};
            inexact_next = 1'b1;
        end else begin
            word_next    = {sign, exp_fin[`FPMUL_EXP_BITS-1:0], frac_rnd[FRAC_BITS-1:0]};
            inexact_next = guard | sticky;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            result_word <= '0;
            inexact     <= 1'b0;
        end else if (capture) begin
            result_word <= word_next;
            inexact     <= inexact_next;
        end
    end

endmodule

/* hdl/fpmul_axil_regs.sv */
/*
 * AXI4-Lite register slave of the fp16 multiply unit.
 * Holds the operand registers, decodes the control and status words
 * and returns the result with its inexact flag.
 */
`timescale 1ns/1ps
`include "fpmul_config.svh"

module fpmul_axil_regs
    import fpmul_pkg::*;
(
    input  logic                            clk,
    input  logic                            nRST,
    input  logic [`FPMUL_AXI_ADDR_BITS-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [`FPMUL_AXI_ADDR_BITS-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    input  logic                            busy,
    input  logic                            done,
    input  logic [15:0]                     result_word,
    input  logic                            inexact,
    output fp16_word_t                      op_a,
    output fp16_word_t                      op_b,
    output logic                            start_req
);

    localparam int AW = `FPMUL_AXI_ADDR_BITS;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic           slave_up;
    logic           aw_full;
    logic           w_full;
    logic           write_fire;
    logic [AW-1:0]  aw_addr_q;
    logic [AW-1:0]  wr_word;
    logic [AW-1:0]  rd_word;
    logic [31:0]    w_data_q;
    logic [3:0]     w_strb_q;
    logic [31:0]    rd_value;

    function automatic logic is_mapped(input logic [AW-1:0] addr);
        return (addr == `FPMUL_REG_OPA) || (addr == `FPMUL_REG_OPB) ||
               (addr == `FPMUL_REG_CTRL) || (addr == `FPMUL_REG_STATUS) ||
               (addr == `FPMUL_REG_RESULT);
    endfunction

    // The channels open one clock after reset and close while a response waits.
    assign awready = slave_up && !aw_full && !bvalid;
    assign wready = slave_up && !w_full && !bvalid;
    assign arready = slave_up && !rvalid;

    // Address and data may arrive in either order; the write happens once both are held.
    assign write_fire = aw_full && w_full;
    assign wr_word = {aw_addr_q[AW-1:2], 2'b00};
    assign rd_word = {araddr[AW-1:2], 2'b00};

    always_comb begin
        case (rd_word)
            `FPMUL_REG_OPA:    rd_value = {16'b0, op_a.raw};
            `FPMUL_REG_OPB:    rd_value = {16'b0, op_b.raw};
            `FPMUL_REG_STATUS: rd_value = {30'b0, done, busy};
            `FPMUL_REG_RESULT: rd_value = {15'b0, inexact, result_word};
            // CTRL reads back as zero just as unmapped space does.
            default:           rd_value = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            slave_up  <= 1'b0;
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= RESP_OKAY;
            rvalid    <= 1'b0;
            rresp     <= RESP_OKAY;
            start_req <= 1'b0;
        end else begin
            slave_up  <= 1'b1;
            start_req <= 1'b0;
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
            end
            if (write_fire) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= is_mapped(wr_word) ? RESP_OKAY : RESP_SLVERR;
                // A start while the multiplier runs is dropped.
                start_req <= (wr_word == `FPMUL_REG_CTRL) && w_data_q[0] && !busy;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rresp  <= is_mapped(rd_word) ? RESP_OKAY : RESP_SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (arvalid && arready) begin
            rdata <= rd_value;
        end
        // Operands take only the lanes enabled by wstrb.
        for (int i = 0; i < 2; i++) begin
            if (write_fire && (wr_word == `FPMUL_REG_OPA) && w_strb_q[i]) begin
                op_a.raw[8*i +: 8] <= w_data_q[8*i +: 8];
            end
            if (write_fire && (wr_word == `FPMUL_REG_OPB) && w_strb_q[i]) begin
                op_b.raw[8*i +: 8] <= w_data_q[8*i +: 8];
            end
        end
    end

endmodule

/* hdl/fpmul_top.sv */
/*
 * Top level of the fp16 multiply unit.
 * Connects the AXI4-Lite slave, the sequencer, the iteration timer,
 * the significand multiplier and the rounding stage.
 */
`timescale 1ns/1ps
`include "fpmul_config.svh"

module fpmul_top
    import fpmul_pkg::*;
(
    input  logic                            clk,
    input  logic                            nRST,
    input  logic [`FPMUL_AXI_ADDR_BITS-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [`FPMUL_AXI_ADDR_BITS-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    fp16_word_t                  op_a;
    fp16_word_t                  op_b;
    logic                        start_req;
    logic                        mul_start;
    logic                        mul_stop;
    logic                        capture;
    logic                        busy;
    logic                        done;
    logic [`FPMUL_MANT_BITS-1:0] mant_a;
    logic [`FPMUL_MANT_BITS-1:0] mant_b;
    logic [`FPMUL_MANT_BITS+1:0] product;
    logic                        mul_overflow;
    logic                        round_loss;
    logic [15:0]                 result_word;
    logic                        inexact;

    fpmul_axil_regs regs0 (
        .clk(clk), .nRST(nRST),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .busy(busy), .done(done), .result_word(result_word), .inexact(inexact),
        .op_a(op_a), .op_b(op_b), .start_req(start_req)
    );

    mul_fsm fsm0 (
        .clk(clk), .nRST(nRST), .start_req(start_req), .stop(mul_stop),
        .mul_start(mul_start), .capture(capture), .busy(busy), .done(done)
    );

    // One iteration per significand bit.
    mul_cycle_timer #(.count_bits(`FPMUL_MANT_BITS)) timer0 (
        .clk(clk), .nRST(nRST), .start(mul_start), .stop(mul_stop)
    );

    mul_multicycle #(.num_bits(`FPMUL_MANT_BITS)) mul0 (
        .clk(clk), .nRST(nRST), .start(mul_start), .stop(mul_stop),
        .op1(mant_a), .op2(mant_b), .result(product),
        .overflow(mul_overflow), .round_loss(round_loss)
    );

    fp16_sign_exp_round round0 (
        .clk(clk), .nRST(nRST), .capture(capture), .op_a(op_a), .op_b(op_b),
        .product(product), .overflow(mul_overflow), .round_loss(round_loss),
        .mant_a(mant_a), .mant_b(mant_b), .result_word(result_word), .inexact(inexact)
    );

endmodule

/* verif/fpmul_assertions.sv */
/*
 * Concurrent checks on the multiply sequencer outputs.
 * Covers the state after reset, the start pulse width,
 * the capture timing and the busy and done exclusion.
 */
`timescale 1ns/1ps
`include "fpmul_config.svh"

module fpmul_assertions (
    input logic clk,
    input logic nRST,
    input logic stop,
    input logic mul_start,
    input logic capture,
    input logic busy,
    input logic done
);

    // Number of assertion failures seen so far.
    int fail_count = 0;

    // The sequencer comes out of reset idle.
    busy_after_reset: assert property (@(posedge clk) $rose(nRST) |-> !busy)
        else begin
            $error("busy is high as reset ends");
            fail_count = fail_count + 1;
        end

    // The multiplier and timer load on a single clock, never two in a row.
    start_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |=> !mul_start)
        else begin
            $error("mul_start is high for more than one cycle");
            fail_count = fail_count + 1;
        end

    // Capture needs stop and falls one load cycle plus one cycle per
    // significand bit after the start pulse.
    capture_after_stop: assert property (@(posedge clk) disable iff (!nRST)
        capture |-> (stop && $past(mul_start, `FPMUL_MANT_BITS + 1)))
        else begin
            $error("capture pulsed without stop or before the full iteration count");
            fail_count = fail_count + 1;
        end

    // Done and busy come from different states.
    done_busy_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(done && busy))
        else begin
            $error("done and busy are high together");
            fail_count = fail_count + 1;
        end

endmodule

bind mul_fsm fpmul_assertions asrt0 (
    .clk(clk), .nRST(nRST), .stop(stop), .mul_start(mul_start),
    .capture(capture), .busy(busy), .done(done)
);

/* verif/fpmul_tb.sv */
/*
 * Testbench for the fp16 multiply unit.
 * Generates clock and reset, drives the AXI4-Lite bus, replays the
 * vectors of the tests file and counts mismatches under a cycle limit.
 */
`timescale 1ns/1ps
`include "fpmul_config.svh"

module fpmul_tb;

    localparam int AW = `FPMUL_AXI_ADDR_BITS;

    logic          clk;
    logic          nRST;
    logic [AW-1:0] awaddr;
    logic          awvalid;
    logic          awready;
    logic [31:0]   wdata;
    logic [3:0]    wstrb;
    logic          wvalid;
    logic          wready;
    logic [1:0]    bresp;
    logic          bvalid;
    logic          bready;
    logic [AW-1:0] araddr;
    logic          arvalid;
    logic          arready;
    logic [31:0]   rdata;
    logic [1:0]    rresp;
    logic          rvalid;
    logic          rready;

    int            errors;
    int            asrt_fails;
    int            cycles = 0;
    int            cycle_limit = 200;
    logic [15:0]   vec_a[$];
    logic [15:0]   vec_b[$];
    logic [15:0]   vec_r[$];
    logic          vec_x[$];

    fpmul_top dut0 (
        .clk(clk), .nRST(nRST),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // The run limit in clock cycles is set from the vector count once the file is read.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_word(input logic [31:0] got, input logic [31:0] expected,
                                input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                     $time, what, got, expected);
            errors = errors + 1;
        end
    endtask

    // Address and data are offered together; the slave may take them in either order.
    task automatic axi_write(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        logic aw_hs;
        logic w_hs;
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        while (!(aw_done && w_done)) begin
            // Mid-cycle values are the ones the next rising edge acts on.
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic ar_hs;
        ar_hs = 1'b0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        while (!ar_hs) begin
            @(negedge clk);
            ar_hs = arvalid && arready;
            @(posedge clk);
        end
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Mapped registers always answer OKAY.
    task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [1:0] resp;
        axi_write(addr, data, strb, resp);
        compare_word({30'b0, resp}, 32'h0, $sformatf("write response at %h", addr));
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        compare_word({30'b0, resp}, 32'h0, $sformatf("read response at %h", addr));
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [3:0]  x;
        fd = $fopen("verif/fpmul_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verif/fpmul_tests.txt");
            errors = errors + 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Lines that start with # hold the column legend.
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h", a, b, r, x);
                if (fields == 4) begin
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_r.push_back(r);
                    vec_x.push_back(x[0]);
                end
            end
        end
        $fclose(fd);
        if (vec_a.size() == 0) begin
            $display("The vector file holds no vectors");
            errors = errors + 1;
        end
    endtask

    task automatic start_multiply(input logic [15:0] a, input logic [15:0] b);
        write_reg(`FPMUL_REG_OPA, {16'h0, a}, 4'hF);
        write_reg(`FPMUL_REG_OPB, {16'h0, b}, 4'hF);
        write_reg(`FPMUL_REG_CTRL, 32'h1, 4'hF);
    endtask

    // Done from the previous run is already cleared once the start write completes.
    task automatic wait_done();
        logic [31:0] status;
        read_reg(`FPMUL_REG_STATUS, status);
        while (status[1] == 1'b0) begin
            read_reg(`FPMUL_REG_STATUS, status);
        end
    endtask

    task automatic check_result(input int i);
        logic [31:0] res;
        read_reg(`FPMUL_REG_RESULT, res);
        compare_word(res, {15'b0, vec_x[i], vec_r[i]},
                     $sformatf("RESULT of vector %0d, %h x %h", i, vec_a[i], vec_b[i]));
    endtask

    task automatic verify_reset_state();
        logic [31:0] value;
        read_reg(`FPMUL_REG_STATUS, value);
        compare_word(value, 32'h0, "STATUS after reset");
        read_reg(`FPMUL_REG_RESULT, value);
        compare_word(value, 32'h0, "RESULT after reset");
    endtask

    // Byte lanes outside wstrb keep their old contents.
    task automatic operand_readback();
        logic [31:0] value;
        write_reg(`FPMUL_REG_OPA, 32'h0000_1234, 4'hF);
        read_reg(`FPMUL_REG_OPA, value);
        compare_word(value, 32'h0000_1234, "OPA readback");
        write_reg(`FPMUL_REG_OPA, 32'h0000_ABCD, 4'b0010);
        read_reg(`FPMUL_REG_OPA, value);
        compare_word(value, 32'h0000_AB34, "OPA after upper byte write");
        write_reg(`FPMUL_REG_OPB, 32'hFFFF_5678, 4'hF);
        read_reg(`FPMUL_REG_OPB, value);
        compare_word(value, 32'h0000_5678, "OPB readback");
        write_reg(`FPMUL_REG_OPB, 32'h0000_00EF, 4'b0001);
        read_reg(`FPMUL_REG_OPB, value);
        compare_word(value, 32'h0000_56EF, "OPB after lower byte write");
    endtask

    task automatic run_vector(input int i);
        start_multiply(vec_a[i], vec_b[i]);
        wait_done();
        check_result(i);
    endtask

    // The second start arrives a few cycles into the 13-cycle busy window.
    task automatic ignored_start();
        logic [31:0] status;
        start_multiply(vec_a[0], vec_b[0]);
        read_reg(`FPMUL_REG_STATUS, status);
        compare_word(status, 32'h1, "STATUS while busy");
        write_reg(`FPMUL_REG_CTRL, 32'h1, 4'hF);
        wait_done();
        check_result(0);
        read_reg(`FPMUL_REG_STATUS, status);
        compare_word(status, 32'h2, "STATUS after a start written while busy");
    endtask

    task automatic unmapped_access();
        logic [1:0]  resp;
        logic [31:0] value;
        axi_write(5'h14, 32'hFFFF_FFFF, 4'hF, resp);
        compare_word({30'b0, resp}, 32'h2, "write response at unmapped 14");
        axi_read(5'h18, value, resp);
        compare_word({30'b0, resp}, 32'h2, "read response at unmapped 18");
        compare_word(value, 32'h0, "read data at unmapped 18");
    endtask

    initial begin
        nRST    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors  = 0;
        load_vectors();
        cycle_limit = vec_a.size() * 60 + 200;
        repeat (8) @(posedge clk);
        nRST <= 1'b1;
        verify_reset_state();
        operand_readback();
        foreach (vec_a[i]) begin
            run_vector(i);
        end
        if (vec_a.size() > 0) begin
            ignored_start();
        end
        unmapped_access();
        asrt_fails = dut0.fsm0.asrt0.fail_count;
        $display("Check errors: %0d, assertion failures: %0d", errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verif/fpmul_tests.txt */
# Columns: operand A, operand B, expected result, expected inexact flag.
# All values are hex; operands and result are IEEE binary16 codes.
3C00 3C00 3C00 0
3E00 4000 4200 0
3E00 3E00 4080 0
C200 4200 C880 0
C000 C200 4600 0
3C01 3C01 3C02 1
3C01 3E00 3E02 1
3C03 3E00 3E04 1
3E00 3D56 4000 1
3E00 3D5A 4004 1
3DA8 3DA8 4000 1
3555 4200 3C00 1
7BFF 3C00 7BFF 0
7BFF 4000 7C00 1
F800 7800 FC00 1
0400 3C00 0400 0
8400 3800 8000 1
0000 4200 0000 0
8000 4200 8000 0
0001 C200 8000 0

/* build.f */
+incdir+include
hdl/fpmul_pkg.sv
hdl/mul_multicycle.sv
hdl/mul_cycle_timer.sv
hdl/mul_fsm.sv
hdl/fp16_sign_exp_round.sv
hdl/fpmul_axil_regs.sv
hdl/fpmul_top.sv
verif/fpmul_assertions.sv
verif/fpmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fp16 multiply testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f build.f --top-module fpmul_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Assertion failures are counted by the testbench, so the run must not stop at the first one.
./obj_dir/Vfpmul_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
